//--- Bender.yml
package:
  name: fclass

sources:
  - include_dirs:
      - hw
    files:
      - hw/fclass_pkg.sv
      - hw/fpUnpack.sv
      - hw/classFifo.sv
      - hw/fpClassify.sv
      - hw/fclassTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/fclassTb.sv

//--- hw/classFifo.sv
/*
 * class-flag entry FIFO
 * circular buffer with occupancy count, full leaves one slot in reserve
 */
`timescale 1ns/1ps
`default_nettype none

`include "fclass_config.svh"

module classFifo (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     push,
  input  fclass_pkg::classEntry_t  entry,
  input  logic                     pop,
  output fclass_pkg::classEntry_t  head,
  output logic                     empty,
  output logic                     full
);

  import fclass_pkg::*;

  localparam int DEPTH = `FCLASS_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  // storage, payload only
  classEntry_t mem [DEPTH];

  // pointers wrap naturally, depth is a power of two
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;

  // one extra bit to reach DEPTH
  logic [PTR_W:0] count;

  //////////////////////////////
  // storage write
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= entry;
    end
  end

  // head visible as soon as it is written
  assign head = mem[rdPtr];

  //////////////////////////////
  // pointers and count
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty = (count == '0);

  // room kept for the entry already registered upstream
  assign full = (count >= (PTR_W + 1)'(DEPTH - 1));

  // upstream gating on full must keep one slot spare
  noOverflow: assert property (@(posedge clk) disable iff (!rstN)
    !(push && count == (PTR_W + 1)'(DEPTH)))
    else $error("push into FIFO holding %0d entries", DEPTH);

  // consumer only pops a valid head
  noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
    !(pop && empty))
    else $error("pop from empty FIFO");

endmodule

`default_nettype wire

//--- hw/fclassTop.sv
/*
 * FCLASS top level
 * unpack, entry FIFO and classify writeback
 */
`timescale 1ns/1ps
`default_nettype none

module fclassTop (
  input  logic                    clk,
  input  logic                    rstN,
  // issue side
  input  logic                    opVld,
  input  fclass_pkg::fpFmt_t      opFmt,
  input  fclass_pkg::fpOperand_t  opData,
  input  fclass_pkg::tag_t        opTag,
  output logic                    full,
  // write side
  input  logic                    wbReady,
  output logic                    resVld,
  output fclass_pkg::xlenWord_t   resData,
  output fclass_pkg::tag_t        resTag
);

  import fclass_pkg::*;

  //////////////////////////////
  // internal links
  //////////////////////////////

  // unpack to FIFO
  logic        push;
  classEntry_t entry;

  // FIFO to classify
  classEntry_t head;
  logic        empty;
  logic        pop;

  fpUnpack u_unpack (
    .clk    (clk),
    .rstN   (rstN),
    .opVld  (opVld),
    .opFmt  (opFmt),
    .opData (opData),
    .opTag  (opTag),
    .full   (full),
    .push   (push),
    .entry  (entry)
  );

  classFifo u_fifo (
    .clk   (clk),
    .rstN  (rstN),
    .push  (push),
    .entry (entry),
    .pop   (pop),
    .head  (head),
    .empty (empty),
    .full  (full)
  );

  fpClassify u_classify (
    .clk     (clk),
    .rstN    (rstN),
    .empty   (empty),
    .head    (head),
    .wbReady (wbReady),
    .pop     (pop),
    .resVld  (resVld),
    .resData (resData),
    .resTag  (resTag)
  );

endmodule

`default_nettype wire

//--- hw/fclass_config.svh
/*
 * FCLASS path configuration
 * integer width, buffer depth and destination tag width
 */
`ifndef FCLASS_CONFIG_SVH
`define FCLASS_CONFIG_SVH

//////////////////////////////
// result width
//////////////////////////////

// integer register width, class mask zero-extended to this
`define FCLASS_XLEN 64

//////////////////////////////
// buffering and tagging
//////////////////////////////

// entries between unpack and classify, power of two
`define FCLASS_FIFO_DEPTH 4

// destination register index width
`define FCLASS_TAG_W 5

`endif

//--- hw/fclass_pkg.sv
/*
 * FCLASS shared types
 * operand, result, tag and class-flag entry definitions
 */
`default_nettype none

`include "fclass_config.svh"

package fclass_pkg;

  //////////////////////////////
  // plain vectors
  //////////////////////////////

  // raw FP register value, single sits in low half
  typedef logic [63:0] fpOperand_t;

  // integer writeback word
  typedef logic [`FCLASS_XLEN-1:0] xlenWord_t;

  // one bit per class, see bit map below
  typedef logic [9:0] classMask_t;

  // destination register index
  typedef logic [`FCLASS_TAG_W-1:0] tag_t;

  // operand format
  typedef enum logic {
    FMT_S = 1'b0,
    FMT_D = 1'b1
  } fpFmt_t;

  //////////////////////////////
  // class mask bit positions
  //////////////////////////////

  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;
  localparam int CLS_QNAN     = 9;

  // unpacked operand as it travels through the buffer
  typedef struct packed {
    logic sgn;
    logic isNaN;
    logic isSNaN;
    logic isSubnorm;
    logic isZero;
    logic isInf;
    tag_t tag;
  } classEntry_t;

endpackage

`default_nettype wire

//--- hw/fpClassify.sv
/*
 * FP classify writeback
 * pops entries, builds the ten-bit one-hot class mask, registers the result
 */
`timescale 1ns/1ps
`default_nettype none

`include "fclass_config.svh"

module fpClassify (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     empty,
  input  fclass_pkg::classEntry_t  head,
  input  logic                     wbReady,
  output logic                     pop,
  output logic                     resVld,
  output fclass_pkg::xlenWord_t    resData,
  output fclass_pkg::tag_t         resTag
);

  import fclass_pkg::*;

  // none of the special classes
  logic isNorm;

  classMask_t mask;

  // write port free and something waiting
  assign pop = ~empty & wbReady;

  //////////////////////////////
  // class mask
  //////////////////////////////

  assign isNorm = ~(head.isNaN | head.isInf | head.isSubnorm | head.isZero);

  always_comb begin
    mask = '0;
    // negative side
    mask[CLS_NEG_INF]  = head.sgn & head.isInf;
    mask[CLS_NEG_NORM] = head.sgn & isNorm;
    mask[CLS_NEG_SUB]  = head.sgn & head.isSubnorm;
    mask[CLS_NEG_ZERO] = head.sgn & head.isZero;
    // positive side
    mask[CLS_POS_ZERO] = ~head.sgn & head.isZero;
    mask[CLS_POS_SUB]  = ~head.sgn & head.isSubnorm;
    mask[CLS_POS_NORM] = ~head.sgn & isNorm;
    mask[CLS_POS_INF]  = ~head.sgn & head.isInf;
    // NaNs ignore sign
    mask[CLS_SNAN]     = head.isSNaN;
    mask[CLS_QNAN]     = head.isNaN & ~head.isSNaN;
  end

  //////////////////////////////
  // writeback registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resVld  <= 1'b0;
      resData <= '0;
    end else begin
      resVld <= pop;
      if (pop) begin
        // upper bits zero
        resData <= {{(`FCLASS_XLEN - 10){1'b0}}, mask};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      resTag <= head.tag;
    end
  end

  // unpack flags must select exactly one class
  oneHotResult: assert property (@(posedge clk) disable iff (!rstN)
    resVld |-> $onehot(resData))
    else $error("class mask not one-hot: %h", resData);

endmodule

`default_nettype wire

//--- hw/fpUnpack.sv
/*
 * FP operand unpack
 * NaN-box check, per-format field split, registered class-flag entry
 */
`timescale 1ns/1ps
`default_nettype none

module fpUnpack (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     opVld,
  input  fclass_pkg::fpFmt_t       opFmt,
  input  fclass_pkg::fpOperand_t   opData,
  input  fclass_pkg::tag_t         opTag,
  input  logic                     full,
  output logic                     push,
  output fclass_pkg::classEntry_t  entry
);

  import fclass_pkg::*;

  // raw fields for the selected format
  logic sgnRaw;
  logic expOnes;
  logic expZero;
  logic fracZero;
  logic fracMsb;

  // single not properly boxed in the upper half
  logic boxBad;

  // issue accepted this cycle
  logic accept;

  classEntry_t nextEntry;

  //////////////////////////////
  // field extraction
  //////////////////////////////

  assign boxBad = (opFmt == FMT_S) && !(&opData[63:32]);

  always_comb begin
    if (opFmt == FMT_D) begin
      // sign 63, exponent 62:52, fraction 51:0
      sgnRaw   = opData[63];
      expOnes  = &opData[62:52];
      expZero  = ~|opData[62:52];
      fracZero = ~|opData[51:0];
      fracMsb  = opData[51];
    end else begin
      // sign 31, exponent 30:23, fraction 22:0
      sgnRaw   = opData[31];
      expOnes  = &opData[30:23];
      expZero  = ~|opData[30:23];
      fracZero = ~|opData[22:0];
      fracMsb  = opData[22];
    end
  end

  //////////////////////////////
  // class flags
  //////////////////////////////

  always_comb begin
    nextEntry.tag = opTag;
    if (boxBad) begin
      // bad box reads as canonical quiet NaN
      nextEntry.sgn       = 1'b0;
      nextEntry.isNaN     = 1'b1;
      nextEntry.isSNaN    = 1'b0;
      nextEntry.isSubnorm = 1'b0;
      nextEntry.isZero    = 1'b0;
      nextEntry.isInf     = 1'b0;
    end else begin
      nextEntry.sgn       = sgnRaw;
      nextEntry.isNaN     = expOnes & ~fracZero;
      // signaling when the quiet bit is clear
      nextEntry.isSNaN    = expOnes & ~fracZero & ~fracMsb;
      nextEntry.isSubnorm = expZero & ~fracZero;
      nextEntry.isZero    = expZero & fracZero;
      nextEntry.isInf     = expOnes & fracZero;
    end
  end

  // strobe while full is dropped
  assign accept = opVld & ~full;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      push <= 1'b0;
    end else begin
      push <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      entry <= nextEntry;
    end
  end

  // issuer must hold off while buffer reports full
  issueWhileFull: assert property (@(posedge clk) disable iff (!rstN)
    !(opVld && full))
    else $error("opVld sampled while full is high");

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/fclass_pkg.sv
hw/fpUnpack.sv
hw/classFifo.sv
hw/fpClassify.sv
hw/fclassTop.sv
tests/fclassTb.sv

//--- tests/fclassTb.sv
/*
 * FCLASS testbench
 * file-driven operands, writeback stalls, in-order result and latency checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "fclass_config.svh"

module fclassTb;

  import fclass_pkg::*;

  localparam int DEPTH   = `FCLASS_FIFO_DEPTH;
  localparam int MAX_VEC = 64;
  localparam int LIMIT   = 200;
  // leading double-precision class vectors run at fixed latency
  localparam int A_LAST  = 10;

  logic       clk = 1'b0;
  logic       rstN;
  logic       opVld;
  fpFmt_t     opFmt;
  fpOperand_t opData;
  tag_t       opTag;
  logic       full;
  logic       wbReady;
  logic       resVld;
  xlenWord_t  resData;
  tag_t       resTag;

  // four raw file words per vector
  logic [63:0] vecMem [4*MAX_VEC];
  logic        vecFmt [MAX_VEC];
  fpOperand_t  vecData [MAX_VEC];
  tag_t        vecTag [MAX_VEC];
  classMask_t  vecMask [MAX_VEC];
  int          numVec = 0;

  // issued vector index and its sampling edge in issue order
  int expQ[$];
  int sampleQ[$];

  int          cyc = 0;
  int          sentCount = 0;
  int          resCount = 0;
  int          errCount = 0;
  bit          prevWb = 1'b0;
  bit          fixedLat = 1'b0;
  int          monIdx;
  int          monSample;
  int          vecIdx = 0;
  int          bpIssues;
  int          resBefore;
  bit          fullSeen;
  int unsigned seedVal;

  fclassTop i_dut (
    .clk     (clk),
    .rstN    (rstN),
    .opVld   (opVld),
    .opFmt   (opFmt),
    .opData  (opData),
    .opTag   (opTag),
    .full    (full),
    .wbReady (wbReady),
    .resVld  (resVld),
    .resData (resData),
    .resTag  (resTag)
  );

  // 40 ns period
  initial begin
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic finishRun();
    $display("run complete: %0d results checked, %0d errors", resCount, errCount);
    if (errCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic reportTimeout(input string what);
    errCount++;
    $display("timeout: %s", what);
    finishRun();
  endtask

  task automatic loadVectors();
    int i;
    bit found;
    i = 0;
    found = 1'b0;
    $readmemh("tests/fclass_input.txt", vecMem);
    while (!found && i < MAX_VEC) begin
      // format word f closes the table
      if (vecMem[4*i] === 64'hf) begin
        found = 1'b1;
      end else begin
        vecFmt[i]  = vecMem[4*i][0];
        vecData[i] = vecMem[4*i+1];
        vecTag[i]  = vecMem[4*i+2][`FCLASS_TAG_W-1:0];
        vecMask[i] = vecMem[4*i+3][9:0];
        numVec++;
        i++;
      end
    end
    if (!found || numVec <= A_LAST) begin
      errCount++;
      $display("data file is missing, has no end marker or holds too few vectors");
      finishRun();
    end
  endtask

  // call just after a rising edge so the DUT samples it at the next one
  task automatic driveOp(input int idx);
    opVld  <= 1'b1;
    opFmt  <= fpFmt_t'(vecFmt[idx]);
    opData <= vecData[idx];
    opTag  <= vecTag[idx];
    expQ.push_back(idx);
    // cyc trails the current edge by one
    sampleQ.push_back(cyc + 2);
    sentCount++;
  endtask

  task automatic issueRange(input int last, input bit randWb);
    int idle;
    int inFlight;
    idle = 0;
    while (vecIdx < last) begin
      @(posedge clk);
      if (randWb) begin
        // low about one cycle in three
        wbReady <= (($urandom % 3) != 0);
      end
      // upper bound on FIFO fill after this edge
      inFlight = sentCount - int'(opVld) - resCount;
      if (!full && inFlight <= DEPTH - 2) begin
        driveOp(vecIdx);
        vecIdx++;
        idle = 0;
      end else begin
        opVld <= 1'b0;
        idle++;
        if (idle > LIMIT) begin
          reportTimeout("issue never resumed, FIFO stayed full");
        end
      end
    end
    @(posedge clk);
    opVld <= 1'b0;
  endtask

  task automatic waitDrain(input string what);
    int waited;
    waited = 0;
    while (expQ.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > LIMIT) begin
        reportTimeout(what);
      end
    end
  endtask

  //////////////////////////////
  // result monitor
  //////////////////////////////

  always @(negedge clk) begin
    cyc++;
    if (rstN && resVld) begin
      // prevWb holds wbReady as sampled at the popping edge
      if (!prevWb) begin
        errCount++;
        $display("result appeared although wbReady was low at the popping edge");
      end
      if (expQ.size() == 0) begin
        errCount++;
        $display("result appeared with no operation outstanding");
      end else begin
        monIdx = expQ.pop_front();
        monSample = sampleQ.pop_front();
        checkValue("resData", resData, {{(`FCLASS_XLEN - 10){1'b0}}, vecMask[monIdx]});
        checkValue("resTag", resTag, vecTag[monIdx]);
        if (fixedLat) begin
          checkValue("resVld latency", cyc - monSample, 2);
        end
      end
      resCount++;
    end
    prevWb = wbReady;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    rstN    = 1'b0;
    opVld   = 1'b0;
    opFmt   = FMT_S;
    opData  = '0;
    opTag   = '0;
    wbReady = 1'b0;
    seedVal = $urandom(32'hc178c8f5);
    loadVectors();

    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    wbReady <= 1'b1;

    // quiet until the first issue
    repeat (3) begin
      @(negedge clk);
      checkValue("resVld", resVld, 0);
      checkValue("full", full, 0);
      checkValue("resData", resData, 0);
    end

    // double precision issued back to back at fixed 2-cycle latency
    fixedLat = 1'b1;
    issueRange(A_LAST, 1'b0);
    waitDrain("double-precision results did not all return");
    fixedLat = 1'b0;

    // writeback held off until full rises
    @(posedge clk);
    wbReady <= 1'b0;
    bpIssues = 0;
    fullSeen = 1'b0;
    resBefore = resCount;
    while (!fullSeen && bpIssues < DEPTH && vecIdx < numVec) begin
      @(posedge clk);
      driveOp(vecIdx);
      vecIdx++;
      bpIssues++;
      @(posedge clk);
      opVld <= 1'b0;
      // entry lands in the FIFO at the next edge
      @(posedge clk);
      @(negedge clk);
      fullSeen = full;
    end
    if (!fullSeen) begin
      errCount++;
      $display("full did not rise while wbReady was held low");
    end else begin
      // one slot stays in reserve for the entry inside unpack
      checkValue("issues until full", bpIssues, DEPTH - 1);
    end
    repeat (4) @(posedge clk);
    if (resCount != resBefore) begin
      errCount++;
      $display("results came out while wbReady was held low");
    end
    wbReady <= 1'b1;
    waitDrain("held results did not drain after wbReady returned");

    // the rest with random writeback stalls
    issueRange(numVec, 1'b1);
    wbReady <= 1'b1;
    waitDrain("results under random stalls did not all return");

    if (resCount != numVec) begin
      errCount++;
      $display("expected %0d results but saw %0d", numVec, resCount);
    end
    finishRun();
  end

endmodule

`default_nettype wire

//--- tests/fclass_input.txt
// columns: format (0 single, 1 double), operand, tag, expected class mask
// a format word of f ends the table
1 FFF0000000000000 00 001
1 BFF0000000000000 01 002
1 800FFFFFFFFFFFFF 02 004
1 8000000000000000 03 008
1 0000000000000000 04 010
1 0000000000000001 05 020
1 400921FB54442D18 06 040
1 7FF0000000000000 07 080
1 7FF0000000000001 08 100
1 7FF8000000000000 09 200
0 FFFFFFFFFF800000 0A 001
0 FFFFFFFFBF800000 0B 002
0 FFFFFFFF80000001 0C 004
0 FFFFFFFF80000000 0D 008
0 FFFFFFFF00000000 0E 010
0 FFFFFFFF007FFFFF 0F 020
0 FFFFFFFF3F800000 10 040
0 FFFFFFFF7F800000 11 080
0 FFFFFFFF7F800001 12 100
0 FFFFFFFF7FC00000 13 200
0 FFFFFFFFFFC00000 14 200
0 FFFFFFFFFF800001 15 100
0 FFFFFFFF00800000 16 040
0 FFFFFFFF7F7FFFFF 17 040
0 000000003F800000 18 200
0 7FFFFFFFFF800000 19 200
0 FFFFFFFE00000000 1A 200
0 0000000000000000 1B 200
0 FFFF00007F800001 1C 200
1 FFF8000000000000 1D 200
1 FFF0000000000001 1E 100
1 7FF7FFFFFFFFFFFF 1F 100
1 0010000000000000 00 040
1 7FEFFFFFFFFFFFFF 01 040
1 000FFFFFFFFFFFFF 02 020
1 8000000000000001 03 004
1 FFEFFFFFFFFFFFFF 04 002
1 00000000FFFFFFFF 05 020
F 0 0 0
